// ==== tb.f ====
clint_pkg.sv
clint_axi_slave.sv
clint_timebase.sv
clint_hart.sv
clint_rdata_mux.sv
clint_top.sv
tb_clk_gen.sv
tb_clint.sv

// ==== run.sh ====
#!/bin/sh
# builds the CLINT testbench with Verilator and runs it, exit status is the test result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_clint -f tb.f -o sim_clint
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_clint
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0

// ==== tb_clint.sv ====
// testbench top for the CLINT, drives AXI traffic into clint_top and checks it against a model
`default_nettype none

module tb_clint;
  timeunit 1ns;
  timeprecision 1ps;
  import clint_pkg::*;

  localparam int NUM_HARTS = 4;
  localparam int ADDR_W    = 32;
  localparam int ID_W      = 4;
  localparam int USER_W    = 1;
  localparam int TIMEOUT   = 1000;
  localparam logic [ADDR_W-1:0] BASE = 32'h0200_0000;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [ID_W-1:0]   id_t;

  // addresses outside every register region
  localparam addr_t HOLES [6] = '{BASE + 32'h10, BASE + 32'h4020, BASE + 32'h8000,
                                  BASE + 32'hBFF0, BASE + 32'hC000, 32'h0100_0000};

  logic clk;
  logic rst;

  logic              aw_valid, aw_ready, w_valid, w_ready, w_last;
  addr_t             aw_addr, ar_addr;
  id_t               aw_id, ar_id, b_id, r_id;
  logic [USER_W-1:0] aw_user, ar_user, b_user, r_user;
  word_t             w_data, r_data;
  strb_t             w_strb;
  logic              b_valid, b_ready, ar_valid, ar_ready, r_valid, r_ready, r_last;
  logic [1:0]        b_resp, r_resp;
  logic [NUM_HARTS-1:0] msip_irq, mtip_irq;

  // register model
  logic  model_msip [NUM_HARTS];
  word_t model_mtimecmp [NUM_HARTS];
  word_t model_mtime;

  int    cycle_cnt = 0;
  logic  r_stalled = 1'b0;
  logic  b_stalled = 1'b0;
  word_t r_data_q;
  id_t   r_id_q;
  id_t   b_id_q;

  tb_clk_gen u_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  clint_top #(
    .NUM_HARTS      (NUM_HARTS),
    .AXI_ADDR_WIDTH (ADDR_W),
    .BASE_ADDR      (BASE),
    .AXI_ID_WIDTH   (ID_W),
    .AXI_USER_WIDTH (USER_W)
  ) u_dut (
    .clk        (clk),
    .rst        (rst),
    .aw_valid_i (aw_valid),
    .aw_ready_o (aw_ready),
    .aw_addr_i  (aw_addr),
    .aw_id_i    (aw_id),
    .aw_user_i  (aw_user),
    .w_valid_i  (w_valid),
    .w_ready_o  (w_ready),
    .w_data_i   (w_data),
    .w_strb_i   (w_strb),
    .w_last_i   (w_last),
    .b_valid_o  (b_valid),
    .b_ready_i  (b_ready),
    .b_resp_o   (b_resp),
    .b_id_o     (b_id),
    .b_user_o   (b_user),
    .ar_valid_i (ar_valid),
    .ar_ready_o (ar_ready),
    .ar_addr_i  (ar_addr),
    .ar_id_i    (ar_id),
    .ar_user_i  (ar_user),
    .r_valid_o  (r_valid),
    .r_ready_i  (r_ready),
    .r_resp_o   (r_resp),
    .r_data_o   (r_data),
    .r_last_o   (r_last),
    .r_id_o     (r_id),
    .r_user_o   (r_user),
    .msip_irq_o (msip_irq),
    .mtip_irq_o (mtip_irq)
  );

  task automatic halt_sim();
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic abort_run(input string msg);
    $display("at %0t ns: %s", $time, msg);
    halt_sim();
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      halt_sim();
    end
  endtask

  task automatic check_id(input string name, input id_t got, input id_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      halt_sim();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      halt_sim();
    end
  endtask

  function automatic word_t merge_bytes(input word_t old, input word_t data, input strb_t strb);
    word_t res;
    res = old;
    for (int b = 0; b < XLEN / 8; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic clint_reg_e region(input addr_t addr, output int hart);
    addr_t      off;
    clint_reg_e kind;
    off  = addr - BASE;
    kind = REG_NONE;
    hart = 0;
    if (off < addr_t'(4 * NUM_HARTS)) begin
      kind = REG_MSIP;
      hart = int'(off >> 2);
    end else if (off >= 32'h4000 && off < 32'h4000 + addr_t'(8 * NUM_HARTS)) begin
      kind = REG_MTIMECMP;
      hart = int'((off - 32'h4000) >> 3);
    end else if (off >= 32'hBFF8 && off < 32'hC000) begin
      kind = REG_MTIME;
    end
    return kind;
  endfunction

  // expected read data from the model
  function automatic word_t expected_read(input addr_t addr);
    int         h;
    clint_reg_e kind;
    word_t      res;
    kind = region(addr, h);
    case (kind)
      REG_MSIP:     res = addr[2] ? {31'b0, model_msip[h], 32'b0} : {63'b0, model_msip[h]};
      REG_MTIMECMP: res = model_mtimecmp[h];
      REG_MTIME:    res = model_mtime;
      default:      res = '0;
    endcase
    return res;
  endfunction

  function automatic void update_model(input addr_t addr, input word_t data, input strb_t strb);
    int         h;
    clint_reg_e kind;
    kind = region(addr, h);
    if (kind == REG_MSIP && strb[addr[2] ? 4 : 0]) begin
      model_msip[h] = data[addr[2] ? 32 : 0];
    end else if (kind == REG_MTIMECMP) begin
      model_mtimecmp[h] = merge_bytes(model_mtimecmp[h], data, strb);
    end else if (kind == REG_MTIME) begin
      model_mtime = merge_bytes(model_mtime, data, strb);
    end
  endfunction

  task automatic write_reg(input addr_t addr, input word_t data, input strb_t strb,
                           output int w_cycle);
    id_t               id;
    logic [USER_W-1:0] user;
    int                waited;
    int                stall;
    id    = id_t'($urandom_range(0, (1 << ID_W) - 1));
    user  = USER_W'($urandom_range(0, 1));
    stall = int'($urandom_range(0, 5));
    aw_valid <= 1'b1;
    aw_addr  <= addr;
    aw_id    <= id;
    aw_user  <= user;
    w_valid  <= 1'b1;
    w_data   <= data;
    w_strb   <= strb;
    w_last   <= 1'b1;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT) abort_run("no AW transfer within the timeout");
    end while (!aw_ready);
    aw_valid <= 1'b0;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT) abort_run("no W transfer within the timeout");
    end while (!w_ready);
    w_cycle = cycle_cnt;
    w_valid <= 1'b0;
    w_last  <= 1'b0;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT) abort_run("b_valid_o never rose within the timeout");
    end while (!b_valid);
    // hold off the response to exercise back-pressure
    repeat (stall) @(posedge clk);
    b_ready <= 1'b1;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT) abort_run("no B transfer within the timeout");
    end while (!(b_valid && b_ready));
    check_id("b_id_o", b_id, id);
    check_bit("b_user_o", b_user[0], user[0]);
    for (int i = 0; i < 2; i++) begin
      check_bit($sformatf("b_resp_o[%0d]", i), b_resp[i], RESP_OKAY[i]);
    end
    b_ready <= 1'b0;
    update_model(addr, data, strb);
  endtask

  task automatic read_reg(input addr_t addr, output word_t data, output int ar_cycle);
    id_t               id;
    logic [USER_W-1:0] user;
    int                waited;
    int                stall;
    id    = id_t'($urandom_range(0, (1 << ID_W) - 1));
    user  = USER_W'($urandom_range(0, 1));
    stall = int'($urandom_range(0, 5));
    ar_valid <= 1'b1;
    ar_addr  <= addr;
    ar_id    <= id;
    ar_user  <= user;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT) abort_run("no AR transfer within the timeout");
    end while (!ar_ready);
    ar_cycle = cycle_cnt;
    ar_valid <= 1'b0;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT) abort_run("r_valid_o never rose within the timeout");
    end while (!r_valid);
    repeat (stall) @(posedge clk);
    r_ready <= 1'b1;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT) abort_run("no R transfer within the timeout");
    end while (!(r_valid && r_ready));
    data = r_data;
    check_id("r_id_o", r_id, id);
    check_bit("r_user_o", r_user[0], user[0]);
    check_bit("r_last_o", r_last, 1'b1);
    for (int i = 0; i < 2; i++) begin
      check_bit($sformatf("r_resp_o[%0d]", i), r_resp[i], RESP_OKAY[i]);
    end
    r_ready <= 1'b0;
  endtask

  task automatic read_expect(input addr_t addr);
    word_t data;
    int    cyc;
    read_reg(addr, data, cyc);
    check_word($sformatf("r_data_o at %h", addr), data, expected_read(addr));
  endtask

  task automatic match_soft_irqs();
    for (int h = 0; h < NUM_HARTS; h++) begin
      check_bit($sformatf("msip_irq_o[%0d]", h), msip_irq[h], model_msip[h]);
    end
  endtask

  task automatic check_reset_values();
    check_bit("ar_ready_o", ar_ready, 1'b1);
    check_bit("aw_ready_o", aw_ready, 1'b1);
    check_bit("w_ready_o", w_ready, 1'b0);
    check_bit("r_valid_o", r_valid, 1'b0);
    check_bit("b_valid_o", b_valid, 1'b0);
    for (int h = 0; h < NUM_HARTS; h++) begin
      check_bit($sformatf("msip_irq_o[%0d]", h), msip_irq[h], 1'b0);
      check_bit($sformatf("mtip_irq_o[%0d]", h), mtip_irq[h], 1'b0);
    end
    for (int h = 0; h < NUM_HARTS; h++) begin
      read_expect(BASE + addr_t'(4 * h));
      read_expect(BASE + 32'h4000 + addr_t'(8 * h));
    end
  endtask

  task automatic toggle_soft_irqs();
    addr_t addr;
    word_t data_on;
    strb_t lane;
    int    cyc;
    for (int h = 0; h < NUM_HARTS; h++) begin
      addr    = BASE + addr_t'(4 * h);
      data_on = addr[2] ? 64'h1_0000_0000 : 64'h1;
      lane    = addr[2] ? 8'hF0 : 8'h0F;
      write_reg(addr, data_on, 8'hFF, cyc);
      match_soft_irqs();
      read_expect(addr);
      // strobe on the other lane only, msip must keep its value
      write_reg(addr, ~data_on, ~lane, cyc);
      match_soft_irqs();
      read_expect(addr);
      write_reg(addr, ~data_on, lane, cyc);
      match_soft_irqs();
      read_expect(addr);
    end
  endtask

  task automatic write_strobed_cmps();
    addr_t addr;
    int    cyc;
    for (int h = 0; h < NUM_HARTS; h++) begin
      addr = BASE + 32'h4000 + addr_t'(8 * h);
      for (int rep = 0; rep < 2; rep++) begin
        write_reg(addr, {$urandom, $urandom}, strb_t'($urandom_range(0, 255)), cyc);
        read_expect(addr);
      end
    end
    // park every compare value out of reach again
    for (int h = 0; h < NUM_HARTS; h++) begin
      addr = BASE + 32'h4000 + addr_t'(8 * h);
      write_reg(addr, '1, 8'hFF, cyc);
      read_expect(addr);
    end
  endtask

  task automatic verify_mtime_count();
    word_t v;
    word_t r1;
    word_t r2;
    int    w_cyc;
    int    ar1;
    int    ar2;
    v = {32'h0000_0012, 32'($urandom)};
    write_reg(BASE + 32'hBFF8, v, 8'hFF, w_cyc);
    read_reg(BASE + 32'hBFF8, r1, ar1);
    read_reg(BASE + 32'hBFF8, r2, ar2);
    if (r1 < v || r1 - v > word_t'(ar1 - w_cyc)) begin
      abort_run($sformatf("mtime read %h out of range after writing %h", r1, v));
    end
    if (r2 <= r1 || r2 - r1 > word_t'(ar2 - ar1)) begin
      abort_run($sformatf("second mtime read %h out of range after %h", r2, r1));
    end
    model_mtime = r2;
  endtask

  task automatic fire_timer_irq();
    word_t t;
    addr_t cmp_addr;
    int    ar_t;
    int    cyc;
    int    th;
    int    waited;
    th       = int'($urandom_range(0, NUM_HARTS - 1));
    cmp_addr = BASE + 32'h4000 + addr_t'(8 * th);
    read_reg(BASE + 32'hBFF8, t, ar_t);
    model_mtime = t;
    write_reg(cmp_addr, t + 64'd300, 8'hFF, cyc);
    check_bit($sformatf("mtip_irq_o[%0d]", th), mtip_irq[th], 1'b0);
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT) abort_run("mtip_irq_o did not rise within the timeout");
      for (int h = 0; h < NUM_HARTS; h++) begin
        if (h != th) check_bit($sformatf("mtip_irq_o[%0d]", h), mtip_irq[h], 1'b0);
      end
    end while (!mtip_irq[th]);
    // compare registered one cycle after mtime reaches t + 300
    if (cycle_cnt - ar_t != 301) begin
      abort_run($sformatf("mtip_irq_o rose %0d cycles after the mtime sample, expected 301",
                          cycle_cnt - ar_t));
    end
    read_expect(cmp_addr);
    write_reg(cmp_addr, '1, 8'hFF, cyc);
    check_bit($sformatf("mtip_irq_o[%0d]", th), mtip_irq[th], 1'b0);
    read_expect(cmp_addr);
  endtask

  task automatic probe_unmapped();
    int cyc;
    for (int i = 0; i < 6; i++) begin
      read_expect(HOLES[i]);
    end
    write_reg(HOLES[0], {$urandom, $urandom}, 8'hFF, cyc);
    write_reg(HOLES[1], {$urandom, $urandom}, 8'hFF, cyc);
    for (int h = 0; h < NUM_HARTS; h++) begin
      read_expect(BASE + addr_t'(4 * h));
      read_expect(BASE + 32'h4000 + addr_t'(8 * h));
    end
    match_soft_irqs();
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // response channels must hold still while stalled
  always @(posedge clk) begin
    if (!rst) begin
      if (r_valid && ar_ready) abort_run("ar_ready_o high while a read response is pending");
      if (b_valid && aw_ready) abort_run("aw_ready_o high while a write response is pending");
      if (r_stalled) begin
        check_bit("r_valid_o", r_valid, 1'b1);
        check_word("r_data_o", r_data, r_data_q);
        check_id("r_id_o", r_id, r_id_q);
      end
      if (b_stalled) begin
        check_bit("b_valid_o", b_valid, 1'b1);
        check_id("b_id_o", b_id, b_id_q);
      end
    end
    r_stalled = r_valid && !r_ready;
    r_data_q  = r_data;
    r_id_q    = r_id;
    b_stalled = b_valid && !b_ready;
    b_id_q    = b_id;
  end

  initial begin
    int waited;
    void'($urandom(67));
    aw_valid <= 1'b0;
    aw_addr  <= '0;
    aw_id    <= '0;
    aw_user  <= '0;
    w_valid  <= 1'b0;
    w_data   <= '0;
    w_strb   <= '0;
    w_last   <= 1'b0;
    b_ready  <= 1'b0;
    ar_valid <= 1'b0;
    ar_addr  <= '0;
    ar_id    <= '0;
    ar_user  <= '0;
    r_ready  <= 1'b0;
    for (int h = 0; h < NUM_HARTS; h++) begin
      model_msip[h]     = 1'b0;
      model_mtimecmp[h] = '1;
    end
    model_mtime = '0;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT) abort_run("reset was never released");
    end while (rst);
    check_reset_values();
    toggle_soft_irqs();
    write_strobed_cmps();
    verify_mtime_count();
    fire_timer_irq();
    probe_unmapped();
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
// testbench clock and synchronous reset source, instantiated once by the testbench top
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 10;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // released on the edge that ends the last reset cycle
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== clint_top.sv ====
// CLINT top level, AXI4 slave with a shared mtime and per-hart msip and mtimecmp registers
`default_nettype none

module clint_top #(
  parameter int                        NUM_HARTS      = 4,
  parameter int                        AXI_ADDR_WIDTH = 32,
  parameter logic [AXI_ADDR_WIDTH-1:0] BASE_ADDR      = 'h0200_0000,
  parameter int                        AXI_ID_WIDTH   = 4,
  parameter int                        AXI_USER_WIDTH = 1,
  localparam int                       HART_W = (NUM_HARTS > 1) ? $clog2(NUM_HARTS) : 1
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          aw_valid_i,
  output logic                          aw_ready_o,
  input  logic [AXI_ADDR_WIDTH-1:0]     aw_addr_i,
  input  logic [AXI_ID_WIDTH-1:0]       aw_id_i,
  input  logic [AXI_USER_WIDTH-1:0]     aw_user_i,
  input  logic                          w_valid_i,
  output logic                          w_ready_o,
  input  clint_pkg::word_t              w_data_i,
  input  clint_pkg::strb_t              w_strb_i,
  input  logic                          w_last_i,
  output logic                          b_valid_o,
  input  logic                          b_ready_i,
  output logic [1:0]                    b_resp_o,
  output logic [AXI_ID_WIDTH-1:0]       b_id_o,
  output logic [AXI_USER_WIDTH-1:0]     b_user_o,
  input  logic                          ar_valid_i,
  output logic                          ar_ready_o,
  input  logic [AXI_ADDR_WIDTH-1:0]     ar_addr_i,
  input  logic [AXI_ID_WIDTH-1:0]       ar_id_i,
  input  logic [AXI_USER_WIDTH-1:0]     ar_user_i,
  output logic                          r_valid_o,
  input  logic                          r_ready_i,
  output logic [1:0]                    r_resp_o,
  output clint_pkg::word_t              r_data_o,
  output logic                          r_last_o,
  output logic [AXI_ID_WIDTH-1:0]       r_id_o,
  output logic [AXI_USER_WIDTH-1:0]     r_user_o,
  // interrupts to the harts
  output logic [NUM_HARTS-1:0]          msip_irq_o,
  output logic [NUM_HARTS-1:0]          mtip_irq_o
);
  import clint_pkg::*;

  logic                 mtime_we;
  logic [NUM_HARTS-1:0] msip_we;
  logic                 msip_wbit;
  logic [NUM_HARTS-1:0] mtimecmp_we;
  word_t                wdata;
  word_t                wmask;

  logic                 rd_capture;
  clint_reg_e           rd_kind;
  logic [HART_W-1:0]    rd_hart;
  logic                 rd_hi;

  word_t                mtime;
  logic [NUM_HARTS-1:0] msip;
  word_t                mtimecmp [NUM_HARTS];

  clint_axi_slave #(
    .NUM_HARTS      (NUM_HARTS),
    .AXI_ADDR_WIDTH (AXI_ADDR_WIDTH),
    .BASE_ADDR      (BASE_ADDR),
    .AXI_ID_WIDTH   (AXI_ID_WIDTH),
    .AXI_USER_WIDTH (AXI_USER_WIDTH)
  ) u_axi_slave (
    .clk           (clk),
    .rst           (rst),
    .aw_valid_i    (aw_valid_i),
    .aw_ready_o    (aw_ready_o),
    .aw_addr_i     (aw_addr_i),
    .aw_id_i       (aw_id_i),
    .aw_user_i     (aw_user_i),
    .w_valid_i     (w_valid_i),
    .w_ready_o     (w_ready_o),
    .w_data_i      (w_data_i),
    .w_strb_i      (w_strb_i),
    .w_last_i      (w_last_i),
    .b_valid_o     (b_valid_o),
    .b_ready_i     (b_ready_i),
    .b_resp_o      (b_resp_o),
    .b_id_o        (b_id_o),
    .b_user_o      (b_user_o),
    .ar_valid_i    (ar_valid_i),
    .ar_ready_o    (ar_ready_o),
    .ar_addr_i     (ar_addr_i),
    .ar_id_i       (ar_id_i),
    .ar_user_i     (ar_user_i),
    .r_valid_o     (r_valid_o),
    .r_ready_i     (r_ready_i),
    .r_resp_o      (r_resp_o),
    .r_last_o      (r_last_o),
    .r_id_o        (r_id_o),
    .r_user_o      (r_user_o),
    .mtime_we_o    (mtime_we),
    .msip_we_o     (msip_we),
    .msip_wbit_o   (msip_wbit),
    .mtimecmp_we_o (mtimecmp_we),
    .wdata_o       (wdata),
    .wmask_o       (wmask),
    .rd_capture_o  (rd_capture),
    .rd_kind_o     (rd_kind),
    .rd_hart_o     (rd_hart),
    .rd_hi_o       (rd_hi)
  );

  clint_timebase u_timebase (
    .clk        (clk),
    .rst        (rst),
    .mtime_we_i (mtime_we),
    .wdata_i    (wdata),
    .wmask_i    (wmask),
    .mtime_o    (mtime)
  );

  for (genvar h = 0; h < NUM_HARTS; h++) begin : g_hart
    clint_hart u_hart (
      .clk           (clk),
      .rst           (rst),
      .msip_we_i     (msip_we[h]),
      .msip_wbit_i   (msip_wbit),
      .mtimecmp_we_i (mtimecmp_we[h]),
      .wdata_i       (wdata),
      .wmask_i       (wmask),
      .mtime_i       (mtime),
      .msip_o        (msip[h]),
      .mtimecmp_o    (mtimecmp[h]),
      .msip_irq_o    (msip_irq_o[h]),
      .mtip_irq_o    (mtip_irq_o[h])
    );
  end

  clint_rdata_mux #(
    .NUM_HARTS (NUM_HARTS)
  ) u_rdata_mux (
    .clk          (clk),
    .rst          (rst),
    .rd_capture_i (rd_capture),
    .rd_kind_i    (rd_kind),
    .rd_hart_i    (rd_hart),
    .rd_hi_i      (rd_hi),
    .mtime_i      (mtime),
    .msip_i       (msip),
    .mtimecmp_i   (mtimecmp),
    .r_data_o     (r_data_o)
  );

endmodule

`default_nettype wire

// ==== clint_rdata_mux.sv ====
// read data collector, latches the addressed register at the AR transfer and holds it
`default_nettype none

module clint_rdata_mux #(
  parameter int  NUM_HARTS = 4,
  localparam int HART_W    = (NUM_HARTS > 1) ? $clog2(NUM_HARTS) : 1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  rd_capture_i,
  input  clint_pkg::clint_reg_e rd_kind_i,
  input  logic [HART_W-1:0]     rd_hart_i,
  input  logic                  rd_hi_i,
  input  clint_pkg::word_t      mtime_i,
  input  logic [NUM_HARTS-1:0]  msip_i,
  input  clint_pkg::word_t      mtimecmp_i [NUM_HARTS],
  output clint_pkg::word_t      r_data_o
);
  import clint_pkg::*;

  word_t msip_word;
  word_t sel;

  always_comb begin
    msip_word = word_t'(msip_i[rd_hart_i]);
    case (rd_kind_i)
      // zero-extended into the lane of the addressed word
      REG_MSIP:     sel = rd_hi_i ? (msip_word << (XLEN / 2)) : msip_word;
      REG_MTIMECMP: sel = mtimecmp_i[rd_hart_i];
      REG_MTIME:    sel = mtime_i;
      default:      sel = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      r_data_o <= '0;
    end else if (rd_capture_i) begin
      r_data_o <= sel;
    end
  end

endmodule

`default_nettype wire

// ==== clint_hart.sv ====
// per-hart msip and mtimecmp registers with the software and timer interrupt outputs
`default_nettype none

module clint_hart (
  input  logic             clk,
  input  logic             rst,
  input  logic             msip_we_i,
  input  logic             msip_wbit_i,
  input  logic             mtimecmp_we_i,
  input  clint_pkg::word_t wdata_i,
  input  clint_pkg::word_t wmask_i,
  input  clint_pkg::word_t mtime_i,
  output logic             msip_o,
  output clint_pkg::word_t mtimecmp_o,
  output logic             msip_irq_o,
  output logic             mtip_irq_o
);
  import clint_pkg::*;

  logic  msip_q;
  word_t mtimecmp_q;
  logic  mtip_q;
  logic  cmp_written;

  always_ff @(posedge clk) begin
    if (rst) begin
      msip_q <= 1'b0;
    end else if (msip_we_i) begin
      msip_q <= msip_wbit_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mtimecmp_q <= MTIMECMP_RESET;
    end else if (mtimecmp_we_i) begin
      mtimecmp_q <= (mtimecmp_q & ~wmask_i) | (wdata_i & wmask_i);
    end
  end

  // unsigned compare, registered
  always_ff @(posedge clk) begin
    if (rst) begin
      mtip_q <= 1'b0;
    end else begin
      mtip_q <= (mtime_i >= mtimecmp_q);
    end
  end

  // set by the first mtimecmp write after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      cmp_written <= 1'b0;
    end else if (mtimecmp_we_i) begin
      cmp_written <= 1'b1;
    end
  end

  assign msip_o     = msip_q;
  assign msip_irq_o = msip_q;
  assign mtimecmp_o = mtimecmp_q;
  assign mtip_irq_o = mtip_q;

  a_no_early_mtip: assert property (@(posedge clk) disable iff (rst)
    !cmp_written |-> !mtip_irq_o);

endmodule

`default_nettype wire

// ==== clint_timebase.sv ====
// shared free-running mtime counter, software writes merge bytewise under the strobe mask
`default_nettype none

module clint_timebase (
  input  logic             clk,
  input  logic             rst,
  input  logic             mtime_we_i,
  input  clint_pkg::word_t wdata_i,
  input  clint_pkg::word_t wmask_i,
  output clint_pkg::word_t mtime_o
);

  // counts clk directly, no prescaler
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_o <= '0;
    end else if (mtime_we_i) begin
      mtime_o <= (mtime_o & ~wmask_i) | (wdata_i & wmask_i);
    end else begin
      mtime_o <= mtime_o + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== clint_axi_slave.sv ====
// AXI4 slave front end of the CLINT, turns bus requests into register strobes and read selects
`default_nettype none

module clint_axi_slave #(
  parameter int                        NUM_HARTS      = 4,
  parameter int                        AXI_ADDR_WIDTH = 32,
  parameter logic [AXI_ADDR_WIDTH-1:0] BASE_ADDR      = 'h0200_0000,
  parameter int                        AXI_ID_WIDTH   = 4,
  parameter int                        AXI_USER_WIDTH = 1,
  localparam int                       HART_W = (NUM_HARTS > 1) ? $clog2(NUM_HARTS) : 1
) (
  input  logic                          clk,
  input  logic                          rst,
  // write address
  input  logic                          aw_valid_i,
  output logic                          aw_ready_o,
  input  logic [AXI_ADDR_WIDTH-1:0]     aw_addr_i,
  input  logic [AXI_ID_WIDTH-1:0]       aw_id_i,
  input  logic [AXI_USER_WIDTH-1:0]     aw_user_i,
  // write data
  input  logic                          w_valid_i,
  output logic                          w_ready_o,
  input  clint_pkg::word_t              w_data_i,
  input  clint_pkg::strb_t              w_strb_i,
  input  logic                          w_last_i,
  // write response
  output logic                          b_valid_o,
  input  logic                          b_ready_i,
  output logic [1:0]                    b_resp_o,
  output logic [AXI_ID_WIDTH-1:0]       b_id_o,
  output logic [AXI_USER_WIDTH-1:0]     b_user_o,
  // read address
  input  logic                          ar_valid_i,
  output logic                          ar_ready_o,
  input  logic [AXI_ADDR_WIDTH-1:0]     ar_addr_i,
  input  logic [AXI_ID_WIDTH-1:0]       ar_id_i,
  input  logic [AXI_USER_WIDTH-1:0]     ar_user_i,
  // read data, payload comes from the read mux
  output logic                          r_valid_o,
  input  logic                          r_ready_i,
  output logic [1:0]                    r_resp_o,
  output logic                          r_last_o,
  output logic [AXI_ID_WIDTH-1:0]       r_id_o,
  output logic [AXI_USER_WIDTH-1:0]     r_user_o,
  // register write side
  output logic                          mtime_we_o,
  output logic [NUM_HARTS-1:0]          msip_we_o,
  output logic                          msip_wbit_o,
  output logic [NUM_HARTS-1:0]          mtimecmp_we_o,
  output clint_pkg::word_t              wdata_o,
  output clint_pkg::word_t              wmask_o,
  // register read side
  output logic                          rd_capture_o,
  output clint_pkg::clint_reg_e         rd_kind_o,
  output logic [HART_W-1:0]             rd_hart_o,
  output logic                          rd_hi_o
);
  import clint_pkg::*;

  typedef enum logic {R_IDLE, R_DATA} r_state_e;
  typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP} w_state_e;

  r_state_e r_state;
  w_state_e w_state;

  logic ar_hs, r_hs, aw_hs, w_hs, b_hs;

  clint_reg_e        ar_kind, aw_kind, wr_kind;
  logic [HART_W-1:0] ar_hart, aw_hart, wr_hart;
  logic              wr_hi;
  logic              lane_strb;

  logic [AXI_ID_WIDTH-1:0]   wr_id, rd_id;
  logic [AXI_USER_WIDTH-1:0] wr_user, rd_user;

  function automatic void decode(
    input  logic [AXI_ADDR_WIDTH-1:0] addr,
    output clint_reg_e                kind,
    output logic [HART_W-1:0]         hart
  );
    logic [AXI_ADDR_WIDTH-1:0] off;
    logic [AXI_ADDR_WIDTH-1:0] rel_msip;
    logic [AXI_ADDR_WIDTH-1:0] rel_cmp;
    logic [AXI_ADDR_WIDTH-1:0] rel_time;
    off      = addr - BASE_ADDR;
    rel_msip = off - AXI_ADDR_WIDTH'(MSIP_OFFSET);
    rel_cmp  = off - AXI_ADDR_WIDTH'(MTIMECMP_OFFSET);
    rel_time = off - AXI_ADDR_WIDTH'(MTIME_OFFSET);
    kind = REG_NONE;
    hart = '0;
    // differences wrap below each region, so one unsigned compare bounds it
    if (rel_msip < AXI_ADDR_WIDTH'(4 * NUM_HARTS)) begin
      kind = REG_MSIP;
      hart = HART_W'(rel_msip >> 2);
    end else if (rel_cmp < AXI_ADDR_WIDTH'(8 * NUM_HARTS)) begin
      kind = REG_MTIMECMP;
      hart = HART_W'(rel_cmp >> 3);
    end else if (rel_time < AXI_ADDR_WIDTH'(8)) begin
      kind = REG_MTIME;
    end
  endfunction

  always_comb begin
    decode(ar_addr_i, ar_kind, ar_hart);
    decode(aw_addr_i, aw_kind, aw_hart);
  end

  assign ar_hs = ar_valid_i && ar_ready_o;
  assign r_hs  = r_valid_o && r_ready_i;
  assign aw_hs = aw_valid_i && aw_ready_o;
  assign w_hs  = w_valid_i && w_ready_o;
  assign b_hs  = b_valid_o && b_ready_i;

  // read side, one beat in flight
  always_ff @(posedge clk) begin
    if (rst) begin
      r_state <= R_IDLE;
    end else if (r_state == R_IDLE && ar_hs) begin
      r_state <= R_DATA;
    end else if (r_state == R_DATA && r_hs) begin
      r_state <= R_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rd_id   <= ar_id_i;
      rd_user <= ar_user_i;
    end
  end

  assign ar_ready_o   = (r_state == R_IDLE);
  assign r_valid_o    = (r_state == R_DATA);
  assign r_last_o     = r_valid_o;
  assign r_resp_o     = RESP_OKAY;
  assign r_id_o       = rd_id;
  assign r_user_o     = rd_user;
  assign rd_capture_o = ar_hs;
  assign rd_kind_o    = ar_kind;
  assign rd_hart_o    = ar_hart;
  assign rd_hi_o      = ar_addr_i[2];

  // write side
  always_ff @(posedge clk) begin
    if (rst) begin
      w_state <= W_IDLE;
    end else begin
      case (w_state)
        W_IDLE: begin
          if (aw_hs) begin
            w_state <= W_DATA;
          end
        end
        W_DATA: begin
          if (w_hs && w_last_i) begin
            w_state <= W_RESP;
          end
        end
        W_RESP: begin
          if (b_hs) begin
            w_state <= W_IDLE;
          end
        end
        default: w_state <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_kind <= REG_NONE;
    end else if (aw_hs) begin
      wr_kind <= aw_kind;
    end
  end

  // every beat of a burst targets the captured address
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      wr_hart <= aw_hart;
      wr_hi   <= aw_addr_i[2];
      wr_id   <= aw_id_i;
      wr_user <= aw_user_i;
    end
  end

  assign aw_ready_o = (w_state == W_IDLE);
  assign w_ready_o  = (w_state == W_DATA);
  assign b_valid_o  = (w_state == W_RESP);
  assign b_resp_o   = RESP_OKAY;
  assign b_id_o     = wr_id;
  assign b_user_o   = wr_user;

  for (genvar b = 0; b < XLEN / 8; b++) begin : g_mask
    assign wmask_o[8*b +: 8] = {8{w_strb_i[b]}};
  end

  assign wdata_o = w_data_i;

  // msip word sits in the lane picked by address bit 2
  assign msip_wbit_o = wr_hi ? w_data_i[XLEN/2] : w_data_i[0];
  assign lane_strb   = wr_hi ? w_strb_i[XLEN/16] : w_strb_i[0];

  assign mtime_we_o = w_hs && (wr_kind == REG_MTIME);

  always_comb begin
    msip_we_o     = '0;
    mtimecmp_we_o = '0;
    if (w_hs && wr_kind == REG_MSIP && lane_strb) begin
      msip_we_o[wr_hart] = 1'b1;
    end
    if (w_hs && wr_kind == REG_MTIMECMP) begin
      mtimecmp_we_o[wr_hart] = 1'b1;
    end
  end

  a_we_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0({mtime_we_o, msip_we_o, mtimecmp_we_o}));

  a_b_stable: assert property (@(posedge clk) disable iff (rst)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_id_o) && $stable(b_user_o));

  a_r_stable: assert property (@(posedge clk) disable iff (rst)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_id_o) && $stable(r_user_o));

endmodule

`default_nettype wire

// ==== clint_pkg.sv ====
// shared widths, register map offsets and response codes, imported by every CLINT module
`default_nettype none

package clint_pkg;

  // register and data bus width
  localparam int XLEN = 64;

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [XLEN/8-1:0] strb_t;

  // decoded register kind of a bus address
  typedef enum logic [1:0] {
    REG_NONE     = 2'd0,
    REG_MSIP     = 2'd1,
    REG_MTIMECMP = 2'd2,
    REG_MTIME    = 2'd3
  } clint_reg_e;

  // offsets from the CLINT base address
  localparam logic [15:0] MSIP_OFFSET     = 16'h0000;
  localparam logic [15:0] MTIMECMP_OFFSET = 16'h4000;
  localparam logic [15:0] MTIME_OFFSET    = 16'hBFF8;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // keeps the timer interrupt quiet out of reset
  localparam word_t MTIMECMP_RESET = '1;

endpackage

`default_nettype wire
